// File: hdl/ethRx_settings.svh
`ifndef ETH_RX_SETTINGS_SVH
`define ETH_RX_SETTINGS_SVH

// Destination address length in bytes.
`define ETH_ADDR_BYTES 6

// Byte index at which the address decision is taken.
`define ETH_DECIDE_CNT 6

// Reflected CRC-32 polynomial and start value.
`define ETH_CRC_POLY 32'hEDB8_8320
`define ETH_CRC_INIT 32'hFFFF_FFFF

`endif

// File: hdl/ethRxPkg.sv
`default_nettype none

package ethRxPkg;

  // Frame byte index, saturating at the top value.
  typedef logic [3:0] byteCntT;

endpackage

`default_nettype wire

// File: hdl/ethRxByteIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ethRxByteIf
  import ethRxPkg::*;
  ();

  logic [7:0] rxData;
  logic       rxValid;
  logic       rxLast;
  byteCntT    byteCnt;   // Index of the byte now on rxData.
  logic       checkEn;   // Frame active and still in the address window.

  modport source
  (
    output rxData,
    output rxValid,
    output rxLast,
    output byteCnt,
    output checkEn
  );

  modport sink
  (
    input rxData,
    input rxValid,
    input rxLast,
    input byteCnt,
    input checkEn
  );

endinterface

`default_nettype wire

// File: hdl/ethRxByteCounter.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethRx_settings.svh"

module ethRxByteCounter
  import ethRxPkg::*;
  (
    input wire        MRxClk,
    input wire        Reset,
    input wire  [7:0] rxDataIn,
    input wire        rxValidIn,
    input wire        rxLastIn,
    ethRxByteIf.source bus
  );

  byteCntT frameCnt;
  logic    inFrame;
  logic    frameActive;
  logic    cntSaturated;

  assign cntSaturated = (frameCnt == byteCntT'(15));

  // A frame is active from its first valid byte up to its last one.
  assign frameActive = inFrame | rxValidIn;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      frameCnt <= '0;
      inFrame  <= 1'b0;
    end
    else if (rxValidIn)
    begin
      if (rxLastIn)
      begin
        frameCnt <= '0;   // Next frame starts at index 0.
        inFrame  <= 1'b0;
      end
      else
      begin
        inFrame <= 1'b1;
        if (!cntSaturated)
        begin
          frameCnt <= frameCnt + byteCntT'(1);
        end
      end
    end
  end

  assign bus.rxData  = rxDataIn;
  assign bus.rxValid = rxValidIn;
  assign bus.rxLast  = rxLastIn;
  assign bus.byteCnt = frameCnt;   // Index travels with its byte.

  // Checking stays open through the decision byte.
  assign bus.checkEn = frameActive & (frameCnt <= byteCntT'(`ETH_DECIDE_CNT));

endmodule

`default_nettype wire

// File: hdl/ethRxCrcHash.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethRx_settings.svh"

module ethRxCrcHash
  import ethRxPkg::*;
  (
    input wire         MRxClk,
    input wire         Reset,
    ethRxByteIf.sink   bus,
    output logic [5:0] crcHash,
    output logic       crcHashGood
  );

  logic [31:0] crcReg;
  logic [31:0] crcBase;
  logic [31:0] crcNext;
  logic        addrByte;
  logic        lastAddrByte;

  // One byte of reflected CRC-32, LSB first.
  function automatic logic [31:0] crcByte(input logic [31:0] crcIn, input logic [7:0] data);
    logic [31:0] c;
    c = crcIn;
    for (int i = 0; i < 8; i++)
    begin
      if (c[0] ^ data[i])
        c = (c >> 1) ^ `ETH_CRC_POLY;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  assign addrByte = bus.rxValid & bus.checkEn &
                    (bus.byteCnt < byteCntT'(`ETH_ADDR_BYTES));

  assign lastAddrByte = bus.rxValid & bus.checkEn &
                        (bus.byteCnt == byteCntT'(`ETH_ADDR_BYTES - 1));

  // Byte 0 starts from the initial value, not from the old frame.
  assign crcBase = (bus.byteCnt == byteCntT'(0)) ? `ETH_CRC_INIT : crcReg;
  assign crcNext = crcByte(crcBase, bus.rxData);

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      crcReg <= `ETH_CRC_INIT;
    else if (addrByte)
      crcReg <= crcNext;
  end

  // Index comes from the next state, so it lines up with the strobe.
  assign crcHash     = crcNext[31:26];
  assign crcHashGood = lastAddrByte;

endmodule

`default_nettype wire

// File: hdl/ethRxAddrType.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethRx_settings.svh"

module ethRxAddrType
  import ethRxPkg::*;
  (
    input wire       MRxClk,
    input wire       Reset,
    ethRxByteIf.sink bus,
    output logic     broadcast,
    output logic     multicast,
    output logic     controlAddr
  );

  // Reserved address of MAC control (pause) frames.
  localparam logic [47:0] ctrlAddrConst = 48'h0180_C200_0001;

  logic       addrByte;
  logic       firstByte;
  logic [7:0] ctrlByte;
  logic       isFF;
  logic       isCtrl;
  int         byteSel;

  assign addrByte  = bus.rxValid & bus.checkEn &
                     (bus.byteCnt < byteCntT'(`ETH_ADDR_BYTES));
  assign firstByte = (bus.byteCnt == byteCntT'(0));

  // Most significant address byte arrives first.
  assign byteSel  = (`ETH_ADDR_BYTES - 1) - int'(bus.byteCnt);
  assign ctrlByte = ctrlAddrConst[8*byteSel +: 8];

  assign isFF   = (bus.rxData == 8'hFF);
  assign isCtrl = (bus.rxData == ctrlByte);

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      broadcast   <= 1'b0;
      multicast   <= 1'b0;
      controlAddr <= 1'b0;
    end
    else if (bus.rxValid & bus.rxLast)
    begin
      broadcast   <= 1'b0;
      multicast   <= 1'b0;
      controlAddr <= 1'b0;
    end
    else if (addrByte)
    begin
      if (firstByte)
      begin
        multicast   <= bus.rxData[0];   // Group bit.
        broadcast   <= isFF;
        controlAddr <= isCtrl;
      end
      else
      begin
        broadcast   <= broadcast & isFF;
        controlAddr <= controlAddr & isCtrl;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/ethRxAddrCheck.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethRx_settings.svh"

module ethRxAddrCheck
  import ethRxPkg::*;
  (
    input wire        MRxClk,
    input wire        Reset,
    ethRxByteIf.sink  bus,
    input wire [47:0] mac,
    input wire [31:0] hash0,
    input wire [31:0] hash1,
    input wire        rBro,
    input wire        rPro,
    input wire        passAll,
    input wire        broadcast,
    input wire        multicast,
    input wire        controlAddr,
    input wire [5:0]  crcHash,
    input wire        crcHashGood,
    output logic      rxAbort,
    output logic      addressMiss
  );

  logic        unicastOK;
  logic        multicastOK;
  logic        broadcastOK;
  logic        addrByte;
  logic        firstByte;
  logic        decide;
  logic        frameEnd;
  logic        macMatch;
  logic [7:0]  macByte;
  logic [31:0] hashWord;
  logic [7:0]  hashByte;
  logic        hashBit;
  logic        addrInvalid;
  logic        addrMissNext;
  int          byteSel;

  assign addrByte  = bus.rxValid & bus.checkEn &
                     (bus.byteCnt < byteCntT'(`ETH_ADDR_BYTES));
  assign firstByte = (bus.byteCnt == byteCntT'(0));
  assign decide    = bus.rxValid & bus.checkEn &
                     (bus.byteCnt == byteCntT'(`ETH_DECIDE_CNT));
  assign frameEnd  = (bus.rxValid & bus.rxLast) | rxAbort;

  // Station MAC compared MSB first.
  assign byteSel  = (`ETH_ADDR_BYTES - 1) - int'(bus.byteCnt);
  assign macByte  = mac[8*byteSel +: 8];
  assign macMatch = (bus.rxData == macByte);

  // Hash table lookup: word, byte, then bit.
  assign hashWord = crcHash[5] ? hash1 : hash0;
  assign hashByte = hashWord[8*crcHash[4:3] +: 8];
  assign hashBit  = hashByte[crcHash[2:0]];

  assign broadcastOK = broadcast & ~rBro;

  assign addrInvalid  = ~(unicastOK | broadcastOK | multicastOK | rPro);
  assign addrMissNext = ~(unicastOK | broadcastOK | multicastOK | (passAll & controlAddr));

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      unicastOK <= 1'b0;
    else if (frameEnd)
      unicastOK <= 1'b0;
    else if (addrByte)
      unicastOK <= macMatch & (firstByte | unicastOK);
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      multicastOK <= 1'b0;
    else if (frameEnd)
      multicastOK <= 1'b0;
    else if (crcHashGood & multicast)
      multicastOK <= hashBit;
  end

  // Single cycle pulse after the decision byte.
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      rxAbort <= 1'b0;
    else
      rxAbort <= decide & addrInvalid;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      addressMiss <= 1'b0;
    else if (decide)
      addressMiss <= addrMissNext;   // Held until the next decision.
  end

endmodule

`default_nettype wire

// File: hdl/ethRxFilter.sv
`timescale 1ns/1ns
`default_nettype none

module ethRxFilter
  (
    input wire        MRxClk,
    input wire        Reset,
    input wire  [7:0] rxData,
    input wire        rxValid,
    input wire        rxLast,
    input wire [47:0] mac,
    input wire [31:0] hash0,
    input wire [31:0] hash1,
    input wire        rBro,
    input wire        rPro,
    input wire        passAll,
    output wire       rxAbort,
    output wire       addressMiss
  );

  wire [5:0] crcHash;
  wire       crcHashGood;
  wire       broadcast;
  wire       multicast;
  wire       controlAddr;

  ethRxByteIf bus ();

  ethRxByteCounter byteCounter_inst
  (
    .MRxClk    (MRxClk),
    .Reset     (Reset),
    .rxDataIn  (rxData),
    .rxValidIn (rxValid),
    .rxLastIn  (rxLast),
    .bus       (bus.source)
  );

  ethRxCrcHash crcHash_inst
  (
    .MRxClk      (MRxClk),
    .Reset       (Reset),
    .bus         (bus.sink),
    .crcHash     (crcHash),
    .crcHashGood (crcHashGood)
  );

  ethRxAddrType addrType_inst
  (
    .MRxClk      (MRxClk),
    .Reset       (Reset),
    .bus         (bus.sink),
    .broadcast   (broadcast),
    .multicast   (multicast),
    .controlAddr (controlAddr)
  );

  ethRxAddrCheck addrCheck_inst
  (
    .MRxClk      (MRxClk),
    .Reset       (Reset),
    .bus         (bus.sink),
    .mac         (mac),
    .hash0       (hash0),
    .hash1       (hash1),
    .rBro        (rBro),
    .rPro        (rPro),
    .passAll     (passAll),
    .broadcast   (broadcast),
    .multicast   (multicast),
    .controlAddr (controlAddr),
    .crcHash     (crcHash),
    .crcHashGood (crcHashGood),
    .rxAbort     (rxAbort),
    .addressMiss (addressMiss)
  );

endmodule

`default_nettype wire

// File: test/tbEthRxFilter.sv
`timescale 1ns/1ns
`default_nettype none

`include "ethRx_settings.svh"

module tbEthRxFilter;

  localparam int frameLen       = 12;
  localparam int mcFrames       = 40;
  localparam int longFrames     = 15 + mcFrames;   // Unicast, broadcast, promiscuous, control.
  localparam int shortBytes     = 3 + 6 + 1;
  localparam int totalBytes     = longFrames * frameLen + shortBytes;
  localparam int watchdogCycles = totalBytes * 3 + 200;

  localparam logic [47:0] bcastAddr = 48'hFFFF_FFFF_FFFF;
  localparam logic [47:0] ctrlAddr  = 48'h0180_C200_0001;

  logic        MRxClk;
  logic        Reset;
  logic [7:0]  rxData;
  logic        rxValid;
  logic        rxLast;
  logic [47:0] mac;
  logic [31:0] hash0;
  logic [31:0] hash1;
  logic        rBro;
  logic        rPro;
  logic        passAll;
  wire         rxAbort;
  wire         addressMiss;

  logic        decideByte;   // High while the seventh byte of a frame is on the bus.
  int          seed;
  int          abortCount = 0;

  ethRxFilter ethRxFilter_inst
  (
    .MRxClk      (MRxClk),
    .Reset       (Reset),
    .rxData      (rxData),
    .rxValid     (rxValid),
    .rxLast      (rxLast),
    .mac         (mac),
    .hash0       (hash0),
    .hash1       (hash1),
    .rBro        (rBro),
    .rPro        (rPro),
    .passAll     (passAll),
    .rxAbort     (rxAbort),
    .addressMiss (addressMiss)
  );

  initial
  begin
    MRxClk = 1'b0;
    forever #2 MRxClk = ~MRxClk;
  end

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic checkValue(input string testName, input string sigName,
                            input logic expected, input logic actual);
    string line;
    assert (actual === expected)
    else
    begin
      line = $sformatf("Error %s %s expected %0b actual %0b",
                       testName, sigName, expected, actual);
      stopOnError(line);
    end
  endtask

  // Reflected CRC-32 walked bit by bit over the address, first byte LSB first.
  function automatic logic [5:0] hashOf(input logic [47:0] dest);
    logic [31:0] crc;
    logic        fb;
    int          idx;
    crc = `ETH_CRC_INIT;
    for (int k = 0; k < 48; k++)
    begin
      idx = 40 - 8 * (k / 8) + (k % 8);
      fb  = crc[0] ^ dest[idx];
      crc = crc >> 1;
      if (fb)
        crc = crc ^ `ETH_CRC_POLY;
    end
    return crc[31:26];
  endfunction

  // Returns {abort, miss} for the current filter settings.
  function automatic logic [1:0] predictResult(input logic [47:0] dest);
    logic [63:0] hashTable;
    logic        uniOK;
    logic        broOK;
    logic        mcHit;
    logic        ctrlOK;
    hashTable = {hash1, hash0};
    uniOK     = (dest == mac);
    broOK     = (dest == bcastAddr) && !rBro;
    mcHit     = dest[40] && hashTable[hashOf(dest)];   // Group bit of the first byte.
    ctrlOK    = (dest == ctrlAddr) && passAll;
    return {!(uniOK || broOK || mcHit || rPro), !(uniOK || broOK || mcHit || ctrlOK)};
  endfunction

  task automatic sendFrame(input logic [47:0] dest, input int len,
                           output logic abortSeen, output logic missSeen);
    int         gap;
    int         i;
    logic [7:0] b;
    abortSeen = 1'b0;
    missSeen  = addressMiss;
    for (i = 0; i < len; i++)
    begin
      gap = $random(seed) & 1;
      repeat (gap)
      begin
        rxValid    = 1'b0;
        rxLast     = 1'b0;
        decideByte = 1'b0;
        @(posedge MRxClk);
        #1;
      end
      if (i < `ETH_ADDR_BYTES)
        b = dest[47 - 8 * i -: 8];
      else
        b = 8'($random(seed));
      rxData     = b;
      rxValid    = 1'b1;
      rxLast     = (i == len - 1);
      decideByte = (i == `ETH_DECIDE_CNT);
      @(posedge MRxClk);
      #1;
      if (i == `ETH_DECIDE_CNT)
      begin
        abortSeen = rxAbort;   // Result lands one clock after the seventh byte.
        missSeen  = addressMiss;
      end
    end
    rxValid    = 1'b0;
    rxLast     = 1'b0;
    decideByte = 1'b0;
    rxData     = 8'h00;
    @(posedge MRxClk);
    #1;
  endtask

  task automatic checkFrame(input string testName, input logic [47:0] dest, input int len);
    logic [1:0] expected;
    logic       abortSeen;
    logic       missSeen;
    logic       missBefore;
    int         abortsBefore;
    expected     = predictResult(dest);
    missBefore   = addressMiss;
    abortsBefore = abortCount;
    sendFrame(dest, len, abortSeen, missSeen);
    if (len > `ETH_DECIDE_CNT)
    begin
      checkValue(testName, "rxAbort", expected[1], abortSeen);
      checkValue(testName, "addressMiss", expected[0], missSeen);
      checkValue(testName, "addressMiss held", expected[0], addressMiss);
    end
    else
    begin
      checkValue(testName, "addressMiss", missBefore, addressMiss);
      checkValue(testName, "rxAbort pulse", 1'b0, abortCount != abortsBefore);
    end
  endtask

  always @(negedge MRxClk)
  begin
    if (rxAbort)
      abortCount <= abortCount + 1;
  end

  assert property (@(negedge MRxClk) disable iff (Reset) rxAbort |-> $past(decideByte))
    else stopOnError("rxAbort was high without a seventh byte in the cycle before");

  assert property (@(negedge MRxClk) disable iff (Reset) $past(rxAbort) |-> !rxAbort)
    else stopOnError("rxAbort stayed high for more than one cycle");

  assert property (@(negedge MRxClk) disable iff (Reset)
                   !$past(decideByte) |-> $stable(addressMiss))
    else stopOnError("addressMiss changed outside a decision");

  assert property (@(negedge MRxClk) Reset |-> (!rxAbort && !addressMiss))
    else stopOnError("rxAbort or addressMiss was high during reset");

  initial
  begin
    repeat (watchdogCycles) @(posedge MRxClk);
    stopOnError("The run timed out before all frames were checked");
  end

  initial
  begin
    logic [47:0] dest;
    seed       = 32'h07f3_ce6f;
    Reset      = 1'b1;
    rxData     = 8'h00;
    rxValid    = 1'b0;
    rxLast     = 1'b0;
    decideByte = 1'b0;
    mac        = 48'h021A_4F33_C807;
    hash0      = 32'h0;
    hash1      = 32'h0;
    rBro       = 1'b0;
    rPro       = 1'b0;
    passAll    = 1'b0;
    repeat (3) @(posedge MRxClk);
    #1;
    Reset = 1'b0;
    checkValue("reset", "rxAbort", 1'b0, rxAbort);
    checkValue("reset", "addressMiss", 1'b0, addressMiss);

    checkFrame("unicastMatch", mac, frameLen);
    for (int k = 0; k < `ETH_ADDR_BYTES; k++)
      checkFrame("unicastByteMiss", mac ^ (48'h5A << (8 * k)), frameLen);

    checkFrame("broadcastAccept", bcastAddr, frameLen);
    rBro = 1'b1;
    checkFrame("broadcastReject", bcastAddr, frameLen);
    rBro = 1'b0;

    for (int k = 0; k < mcFrames; k++)
    begin
      hash0    = $random(seed);
      hash1    = $random(seed);
      dest     = {16'($random(seed)), 32'($random(seed))};
      dest[40] = 1'b1;
      checkFrame("multicastHash", dest, frameLen);
    end

    hash0 = 32'h0;
    hash1 = 32'h0;
    rPro  = 1'b1;   // Everything passes, miss still reported.
    for (int k = 0; k < 4; k++)
    begin
      dest     = {16'($random(seed)), 32'($random(seed))};
      dest[40] = 1'b0;
      checkFrame("promiscuous", dest, frameLen);
    end
    rPro = 1'b0;

    passAll = 1'b1;
    checkFrame("controlPassAll", ctrlAddr, frameLen);
    passAll = 1'b0;
    checkFrame("controlNoPassAll", ctrlAddr, frameLen);

    // A decision here would clear the miss left by the last frame.
    checkFrame("shortFrame", mac, 3);
    checkFrame("shortFrame", mac, 6);
    checkFrame("shortFrame", mac, 1);

    // Reset in mid run clears the held miss.
    Reset = 1'b1;
    repeat (3) @(posedge MRxClk);
    #1;
    Reset = 1'b0;
    checkValue("resetAfterFrames", "rxAbort", 1'b0, rxAbort);
    checkValue("resetAfterFrames", "addressMiss", 1'b0, addressMiss);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: ethRxFilter.f
+incdir+hdl
hdl/ethRxPkg.sv
hdl/ethRxByteIf.sv
hdl/ethRxByteCounter.sv
hdl/ethRxCrcHash.sv
hdl/ethRxAddrType.sv
hdl/ethRxAddrCheck.sv
hdl/ethRxFilter.sv
test/tbEthRxFilter.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f ethRxFilter.f --top-module tbEthRxFilter -o simv

output=$(./obj_dir/simv 2>&1) || true
echo "$output"

if grep -qx "Verification passed" <<< "$output"
then
  exit 0
else
  exit 1
fi
